// File: src/node_pkg.sv
package node_pkg;

	// ==============================
	// Bus and memory widths
	// ==============================

	localparam int ADDR_W = 32; // APB byte address width
	localparam int DATA_W = 32; // One bus word
	localparam int STRB_W = 4; // Byte lanes per word
	localparam int BYTE_W = DATA_W / STRB_W; // Bits per byte lane

	// Region field sits in the top address bits
	localparam int REGION_LSB = 18;
	localparam int REGION_W = ADDR_W - REGION_LSB; // 14 bits, paddr[31:18]

	localparam logic [REGION_W-1:0] REGION_SHARED = '0; // Word RAM seen by both ports
	localparam logic [REGION_W-1:0] REGION_SCRATCH = REGION_W'(1); // Private scratchpad

	localparam int SHARED_ADDR_W = 10; // Word address into the shared RAM
	localparam int RD_LATENCY = 2; // Cycles from enable to read data

	// ==============================
	// Bus and memory request types
	// ==============================

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [STRB_W-1:0] pstrb; // Byte strobes, only meaningful on writes
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// One memory port request, en qualifies the whole bundle
	typedef struct packed {
		logic en;
		logic [STRB_W-1:0] we; // Per byte write enables, all low for a read
		logic [SHARED_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

endpackage

// File: src/shared_ram.sv
`timescale 1ns/100ps

module shared_ram import node_pkg::*; (
	input  logic clk_i,
	input  mem_req_t req_a_i,
	input  mem_req_t req_b_i,
	output logic [DATA_W-1:0] rdata_a_o,
	output logic [DATA_W-1:0] rdata_b_o
);

	localparam int DEPTH = 2 ** SHARED_ADDR_W;
	localparam int PORTS = 2;

	logic [DATA_W-1:0] mem [DEPTH];
	mem_req_t [PORTS-1:0] req; // Index 0 is port A, index 1 is port B
	logic [DATA_W-1:0] rd_q1 [PORTS]; // Registered array output
	logic [DATA_W-1:0] rd_q2 [PORTS]; // Output register stage

	assign req = {req_b_i, req_a_i};

	// ==============================
	// Write side
	// ==============================

	// Port B is applied before port A in the same block
	// On a same word collision the later assignment sticks, so port A bytes win
	always_ff @(posedge clk_i) begin
		for (int p = PORTS - 1; p >= 0; p--) begin
			if (req[p].en) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (req[p].we[b]) begin
						mem[req[p].addr][b*BYTE_W +: BYTE_W] <=
							req[p].wdata[b*BYTE_W +: BYTE_W];
					end
				end
			end
		end
	end

	// ==============================
	// Read side
	// ==============================

	// Reads see the array before this edge's writes land, which gives read first
	// A read racing a write on the other port therefore returns the old word
	always_ff @(posedge clk_i) begin
		for (int p = 0; p < PORTS; p++) begin
			if (req[p].en) begin
				rd_q1[p] <= mem[req[p].addr];
			end
			rd_q2[p] <= rd_q1[p]; // Second stage keeps the two cycle latency
		end
	end

	assign rdata_a_o = rd_q2[0];
	assign rdata_b_o = rd_q2[1];

endmodule

// File: src/core_port.sv
`timescale 1ns/100ps

module core_port import node_pkg::*; #(
	parameter int SCRATCH_ADDR_W = 8
) (
	input  logic clk_i,
	input  logic reset_i,
	input  apb_req_t req_i,
	output apb_rsp_t rsp_o,
	output mem_req_t shared_req_o,
	input  logic [DATA_W-1:0] shared_rdata_i
);

	localparam int CNT_W = $clog2(RD_LATENCY + 1); // Wide enough to reach RD_LATENCY
	localparam int SCRATCH_DEPTH = 2 ** SCRATCH_ADDR_W;

	logic [REGION_W-1:0] region;
	logic access; // Access phase of an APB transfer
	logic first_cycle; // First access cycle, the only one that enables a memory
	logic hit_shared;
	logic hit_scratch;
	logic unmapped;
	logic ready;
	logic slverr;
	logic [CNT_W-1:0] wait_cnt;
	logic [STRB_W-1:0] byte_we;
	logic [DATA_W-1:0] read_word;

	logic [DATA_W-1:0] scratch_mem [SCRATCH_DEPTH];
	logic [SCRATCH_ADDR_W-1:0] scratch_addr;
	logic scratch_en;
	logic [DATA_W-1:0] scratch_q1; // First read stage
	logic [DATA_W-1:0] scratch_q2; // Second read stage, lines up with the shared RAM

	// ==============================
	// Region decode
	// ==============================

	assign region = req_i.paddr[ADDR_W-1:REGION_LSB];
	assign hit_shared = (region == REGION_SHARED);
	assign hit_scratch = (region == REGION_SCRATCH);
	assign unmapped = ~hit_shared & ~hit_scratch; // Network interface space in the full node

	assign access = req_i.psel & req_i.penable;
	assign first_cycle = access & (wait_cnt == '0);

	// Strobes only count on a write, a read leaves every lane alone
	assign byte_we = req_i.pwrite ? req_i.pstrb : '0;

	// ==============================
	// Shared RAM request
	// ==============================

	// One enable per transfer, later access cycles just wait for the data
	always_comb begin
		shared_req_o.en = first_cycle & hit_shared;
		shared_req_o.we = (first_cycle & hit_shared) ? byte_we : '0;
		shared_req_o.addr = req_i.paddr[SHARED_ADDR_W+1:2]; // Word address, byte offset dropped
		shared_req_o.wdata = req_i.pwdata;
	end

	// ==============================
	// Private scratchpad
	// ==============================

	assign scratch_en = first_cycle & hit_scratch;
	assign scratch_addr = req_i.paddr[SCRATCH_ADDR_W+1:2];

	always_ff @(posedge clk_i) begin
		if (scratch_en) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (byte_we[b]) begin
					scratch_mem[scratch_addr][b*BYTE_W +: BYTE_W] <=
						req_i.pwdata[b*BYTE_W +: BYTE_W]; // Byte lane write
				end
			end
		end
	end

	// Read first, so a write cycle returns the old word like the shared RAM does
	always_ff @(posedge clk_i) begin
		if (scratch_en) begin
			scratch_q1 <= scratch_mem[scratch_addr];
		end
		scratch_q2 <= scratch_q1; // Free running second stage
	end

	// ==============================
	// Wait states and response
	// ==============================

	// Counts access cycles until the read data has come through both stages
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wait_cnt <= '0;
		end else if (access & ~ready) begin
			wait_cnt <= wait_cnt + 1'b1; // Still waiting on the memory
		end else begin
			wait_cnt <= '0; // Idle, setup, or the completing cycle
		end
	end

	// Unmapped accesses finish at once, mapped ones after RD_LATENCY cycles
	assign ready = access & (unmapped | (wait_cnt == CNT_W'(RD_LATENCY)));
	assign slverr = access & unmapped;

	// Data source follows the region of the transfer in flight
	assign read_word = hit_scratch ? scratch_q2 : shared_rdata_i;

	always_comb begin
		rsp_o.pready = ready;
		rsp_o.pslverr = slverr;
		// Only a completing mapped read drives data onto prdata
		rsp_o.prdata = (ready & ~req_i.pwrite & ~unmapped) ? read_word : '0;
	end

endmodule

// File: src/node_top.sv
`timescale 1ns/100ps

module node_top import node_pkg::*; #(
	parameter int SCRATCH_ADDR_W = 8 // Scratchpad word address width, both ports alike
) (
	input  logic clk_i,
	input  logic reset_i,
	input  apb_req_t port0_req_i,
	input  apb_req_t port1_req_i,
	output apb_rsp_t port0_rsp_o,
	output apb_rsp_t port1_rsp_o
);

	// ==============================
	// Port to shared RAM wiring
	// ==============================

	mem_req_t port0_mem_req;
	mem_req_t port1_mem_req;
	logic [DATA_W-1:0] port0_mem_rdata;
	logic [DATA_W-1:0] port1_mem_rdata;

	// Core 0 bus, also the winning side of the shared RAM
	core_port #(
		.SCRATCH_ADDR_W(SCRATCH_ADDR_W)
	) u_port0 (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(port0_req_i),
		.rsp_o(port0_rsp_o),
		.shared_req_o(port0_mem_req),
		.shared_rdata_i(port0_mem_rdata)
	);

	// Core 1 bus
	core_port #(
		.SCRATCH_ADDR_W(SCRATCH_ADDR_W)
	) u_port1 (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(port1_req_i),
		.rsp_o(port1_rsp_o),
		.shared_req_o(port1_mem_req),
		.shared_rdata_i(port1_mem_rdata)
	);

	// Port A takes core 0 so core 0 wins write collisions
	shared_ram u_shared_ram (
		.clk_i(clk_i),
		.req_a_i(port0_mem_req),
		.req_b_i(port1_mem_req),
		.rdata_a_o(port0_mem_rdata),
		.rdata_b_o(port1_mem_rdata)
	);

endmodule

// File: verification/node_checker.sv
`timescale 1ns/100ps

module node_checker import node_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  apb_req_t port0_req_i,
	input  apb_req_t port1_req_i,
	input  apb_rsp_t port0_rsp_i,
	input  apb_rsp_t port1_rsp_i,
	input  logic [DATA_W-1:0] exp_rdata0_i, // Expected prdata for the row on port 0
	input  logic [DATA_W-1:0] exp_rdata1_i,
	input  logic exp_err_i, // Row targets an unmapped region
	output int err_count_o
);

	localparam int MAPPED_CYCLES = 3; // A mapped transfer ends in its third access cycle

	int access_cnt [2]; // Access cycles seen so far in the transfer in flight
	int errors = 0;

	assign err_count_o = errors;

	// Checks one port at a clock edge, a completing edge also checks the data
	task automatic check_port(input int port, input apb_req_t req, input apb_rsp_t rsp,
		input logic [DATA_W-1:0] exp_rdata);
		int needed;
		needed = exp_err_i ? 1 : MAPPED_CYCLES; // Unmapped in cycle 1, mapped in cycle 3
		if (req.psel & req.penable) begin
			access_cnt[port]++;
			if (rsp.pready) begin
				if (access_cnt[port] != needed) begin
					errors++;
					$display("Port %0d completed in access cycle %0d instead of %0d",
						port, access_cnt[port], needed);
				end
				if (rsp.prdata !== exp_rdata) begin
					errors++;
					$display("FAIL port%0d_rsp_o.prdata got 0x%08h expected 0x%08h",
						port, rsp.prdata, exp_rdata);
				end
				if (rsp.pslverr !== exp_err_i) begin
					errors++;
					$display("FAIL port%0d_rsp_o.pslverr got 0x%0h expected 0x%0h",
						port, rsp.pslverr, exp_err_i);
				end
				access_cnt[port] = 0;
			end else if (access_cnt[port] == needed) begin
				errors++; // Flagged once, the timeout ends a transfer that never finishes
				$display("Port %0d still has pready low in access cycle %0d", port, needed);
			end
		end else begin
			access_cnt[port] = 0;
			if (rsp.pready) begin
				errors++;
				$display("Port %0d raised pready outside an access phase", port);
			end
		end
	endtask

	// Outputs are settled well before the edge since the testbench drives after it
	always @(posedge clk_i) begin
		if (reset_i) begin
			access_cnt[0] = 0;
			access_cnt[1] = 0;
		end else begin
			check_port(0, port0_req_i, port0_rsp_i, exp_rdata0_i);
			check_port(1, port1_req_i, port1_rsp_i, exp_rdata1_i);
		end
	end

endmodule

// File: verification/tb_node.sv
`timescale 1ns/100ps

module tb_node import node_pkg::*; ();

	localparam int NUM_ROWS = 13;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLE_LIMIT = NUM_ROWS * 5 + RESET_CYCLES + 20; // Five cycles per row at most

	// One table row, an unused port's columns stay zero
	typedef struct packed {
		logic [1:0] ports; // Bit 0 is port 0, bit 1 is port 1
		logic write;
		logic [STRB_W-1:0] strb;
		logic err; // Expected pslverr
		logic [19:0] addr0; // Bits 19:18 pick the region
		logic [DATA_W-1:0] wdata0;
		logic [DATA_W-1:0] exp0;
		logic [19:0] addr1;
		logic [DATA_W-1:0] wdata1;
		logic [DATA_W-1:0] exp1;
	} row_t;

	logic clk;
	logic reset;
	apb_req_t port0_req;
	apb_req_t port1_req;
	apb_rsp_t port0_rsp;
	apb_rsp_t port1_rsp;
	row_t rows [NUM_ROWS];
	logic [DATA_W-1:0] exp_rdata0;
	logic [DATA_W-1:0] exp_rdata1;
	logic exp_err;
	int checker_errors;
	int cycle_count;

	node_top #(
		.SCRATCH_ADDR_W(8)
	) node_top_i (
		.clk_i(clk),
		.reset_i(reset),
		.port0_req_i(port0_req),
		.port1_req_i(port1_req),
		.port0_rsp_o(port0_rsp),
		.port1_rsp_o(port1_rsp)
	);

	node_checker checker_i (
		.clk_i(clk),
		.reset_i(reset),
		.port0_req_i(port0_req),
		.port1_req_i(port1_req),
		.port0_rsp_i(port0_rsp),
		.port1_rsp_i(port1_rsp),
		.exp_rdata0_i(exp_rdata0),
		.exp_rdata1_i(exp_rdata1),
		.exp_err_i(exp_err),
		.err_count_o(checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// ==============================
	// Stimulus table
	// ==============================

	// Columns: ports, write, strb, err, addr0, wdata0, exp0, addr1, wdata1, exp1
	task automatic fill_table();
		rows[0] = '{2'b01, 1'b1, 4'hF, 1'b0, 20'h00010, 32'h11223344, 32'h0, // Shared write
			20'h0, 32'h0, 32'h0};
		rows[1] = '{2'b10, 1'b0, 4'h0, 1'b0, 20'h0, 32'h0, 32'h0, // Read back on the other port
			20'h00010, 32'h0, 32'h11223344};
		rows[2] = '{2'b10, 1'b1, 4'h5, 1'b0, 20'h0, 32'h0, 32'h0, // Bytes 0 and 2 only
			20'h00010, 32'hAABBCCDD, 32'h0};
		rows[3] = '{2'b01, 1'b0, 4'h0, 1'b0, 20'h00010, 32'h0, 32'h11BB33DD,
			20'h0, 32'h0, 32'h0};
		rows[4] = '{2'b11, 1'b1, 4'hF, 1'b0, 20'h40020, 32'hC0C00000, 32'h0, // Same scratch offset
			20'h40020, 32'hC1C11111, 32'h0};
		rows[5] = '{2'b11, 1'b0, 4'h0, 1'b0, 20'h40020, 32'h0, 32'hC0C00000,
			20'h40020, 32'h0, 32'hC1C11111};
		rows[6] = '{2'b01, 1'b1, 4'hF, 1'b1, 20'h80010, 32'hDEADBEEF, 32'h0, // Region 2
			20'h0, 32'h0, 32'h0};
		rows[7] = '{2'b10, 1'b0, 4'h0, 1'b1, 20'h0, 32'h0, 32'h0, // Region 3 read gives zero
			20'hC0010, 32'h0, 32'h0};
		rows[8] = '{2'b01, 1'b0, 4'h0, 1'b0, 20'h00010, 32'h0, 32'h11BB33DD,
			20'h0, 32'h0, 32'h0};
		rows[9] = '{2'b11, 1'b1, 4'hF, 1'b0, 20'h00040, 32'h5A5A5A5A, 32'h0, // Write collision
			20'h00040, 32'hA5A5A5A5, 32'h0};
		rows[10] = '{2'b11, 1'b0, 4'h0, 1'b0, 20'h00040, 32'h0, 32'h5A5A5A5A,
			20'h00040, 32'h0, 32'h5A5A5A5A};
		rows[11] = '{2'b11, 1'b1, 4'hF, 1'b0, 20'h00080, 32'h01010101, 32'h0,
			20'h00084, 32'h02020202, 32'h0};
		rows[12] = '{2'b11, 1'b0, 4'h0, 1'b0, 20'h00084, 32'h0, 32'h02020202, // Crossed reads
			20'h00080, 32'h0, 32'h01010101};
	endtask

	// Setup phase request, penable is raised a cycle later
	function automatic apb_req_t make_req(input logic sel, input logic write,
		input logic [STRB_W-1:0] strb, input logic [19:0] addr, input logic [DATA_W-1:0] wdata);
		apb_req_t req;
		req.psel = sel;
		req.penable = 1'b0;
		req.pwrite = write;
		req.pstrb = strb;
		req.paddr = {12'h000, addr};
		req.pwdata = wdata;
		return req;
	endfunction

	// Runs one row, entered and left 1 ns after a rising edge
	task automatic run_row(input int r);
		row_t row;
		logic [1:0] pending;
		logic [1:0] done;
		row = rows[r];
		exp_rdata0 = row.exp0;
		exp_rdata1 = row.exp1;
		exp_err = row.err;
		port0_req = make_req(row.ports[0], row.write, row.strb, row.addr0, row.wdata0);
		port1_req = make_req(row.ports[1], row.write, row.strb, row.addr1, row.wdata1);
		@(posedge clk);
		#1;
		port0_req.penable = row.ports[0];
		port1_req.penable = row.ports[1];
		pending = row.ports;
		while (pending != 2'b00) begin
			@(negedge clk); // pready is stable mid cycle
			done = pending & {port1_rsp.pready, port0_rsp.pready};
			@(posedge clk);
			#1;
			if (done[0]) begin
				port0_req.psel = 1'b0;
				port0_req.penable = 1'b0;
			end
			if (done[1]) begin
				port1_req.psel = 1'b0;
				port1_req.penable = 1'b0;
			end
			pending = pending & ~done;
		end
	endtask

	// ==============================
	// Main sequence and timeout
	// ==============================

	initial begin
		reset = 1'b1;
		port0_req = '0;
		port1_req = '0;
		exp_rdata0 = '0;
		exp_rdata1 = '0;
		exp_err = 1'b0;
		fill_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk); // One idle cycle, the checker sees both pready outputs low here
		#1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("Errors: %0d", checker_errors);
		if (checker_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: src.f
src/node_pkg.sv
src/shared_ram.sv
src/core_port.sv
src/node_top.sv
verification/node_checker.sv
verification/tb_node.sv

// File: run_sim.sh
#!/bin/sh
# Builds the node testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --timescale 1ns/100ps --top-module tb_node \
	-f src.f --Mdir "$BUILD" -o sim_node
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/sim_node" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

# The testbench prints the fail line on any failed check or timeout
if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0
